/* lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

//////////////////////////////////////////////////
// reset state of the pipeline
//////////////////////////////////////////////////

// address of the first instruction fetch
`define LC3B_RESET_PC 16'h0000

// condition code out of reset
// only the zero flag is set, so BRz is taken before any setcc
`define LC3B_RESET_CC 3'b010

`endif

/* lc3b_types.sv */
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	// negative, zero, positive
	typedef logic [2:0] lc3b_nzp;

	// full opcode map, unsupported ones decode as nop
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// low five bits of ADD/AND, meaning picked by the imm flag
	typedef union packed {
		logic [4:0] imm5;
		struct packed {
			logic [1:0] zero;
			lc3b_reg src2;
		} sr;
	} lc3b_operand;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg src1;
		logic imm;
		lc3b_operand operand;
	} lc3b_op_view;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg base;
		logic [5:0] offset6;
	} lc3b_mem_view;

	// LEA shares this layout, with nzp holding DR
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_nzp nzp;
		logic [8:0] offset9;
	} lc3b_br_view;

	typedef union packed {
		lc3b_op_view op;
		lc3b_mem_view mem;
		lc3b_br_view br;
	} lc3b_instr;

endpackage : lc3b_types

/* lc3b_pipe_pkg.sv */
package lc3b_pipe_pkg;

	import lc3b_types::*;

	typedef enum logic [1:0] {
		alu_add = 2'b00,
		alu_and = 2'b01,
		alu_not = 2'b10
	} lc3b_aluop;

	// control word, built in decode and carried to writeback
	typedef struct packed {
		lc3b_aluop aluop;
		logic use_imm;
		logic load;
		logic store;
		logic byte_op;
		logic reg_write;
		logic load_cc;
		logic branch;
		logic lea;
	} lc3b_ctrl;

	typedef struct packed {
		logic valid;
		lc3b_word pc2;
		lc3b_instr instr;
		lc3b_ctrl ctrl;
		lc3b_word src1;
		lc3b_word src2;
		lc3b_reg dest;
	} lc3b_de_ex;

	// result holds the ALU value, LEA value or memory address
	typedef struct packed {
		logic valid;
		lc3b_ctrl ctrl;
		lc3b_word result;
		lc3b_word store_data;
		lc3b_reg dest;
	} lc3b_ex_mem;

	typedef struct packed {
		logic reg_write;
		lc3b_reg dest;
		lc3b_word value;
		logic load_cc;
	} lc3b_wb;

endpackage : lc3b_pipe_pkg

/* fetch_stage.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input logic mem_resp_a,
	input lc3b_types::lc3b_word mem_rdata_a,
	input logic stall,
	input logic redirect,
	input lc3b_types::lc3b_word redirect_pc,
	output logic mem_read_a,
	output lc3b_types::lc3b_word mem_address_a,
	output lc3b_types::lc3b_word instr,
	output lc3b_types::lc3b_word instr_pc2,
	output logic instr_valid
);
	import lc3b_types::*;

	logic req, drop, buf_valid;
	logic fill, consume, issue;
	lc3b_word pc, next_pc, pc_plus2, target;
	lc3b_word buf_instr, buf_pc2;

	assign pc_plus2 = pc + 16'd2;
	// response is kept only if no redirect came since the request
	assign fill = req & mem_resp_a & ~drop & ~redirect;
	assign consume = buf_valid & ~stall;
	// new read once the buffer is empty after this edge
	assign issue = (~buf_valid | consume | redirect) & ~fill & (~req | mem_resp_a);
	assign target = redirect ? redirect_pc : (fill ? pc_plus2 : next_pc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			drop <= 1'b0;
			buf_valid <= 1'b0;
			pc <= `LC3B_RESET_PC;
			next_pc <= `LC3B_RESET_PC;
		end else begin
			next_pc <= target;
			if (issue) begin
				req <= 1'b1;
				pc <= target;
			end else if (req && mem_resp_a) begin
				req <= 1'b0;
			end
			// stale read still on the port, ignore its response
			if (req && mem_resp_a)
				drop <= 1'b0;
			else if (req && redirect)
				drop <= 1'b1;
			if (fill)
				buf_valid <= 1'b1;
			else if (consume || redirect)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			buf_instr <= mem_rdata_a;
			buf_pc2 <= pc_plus2;
		end
	end

	assign mem_read_a = req;
	assign mem_address_a = pc;
	assign instr = buf_instr;
	assign instr_pc2 = buf_pc2;
	assign instr_valid = buf_valid;

endmodule : fetch_stage

/* decode_stage.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module decode_stage (
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word instr_pc2,
	input logic instr_valid,
	input logic flush,
	input logic hold,
	input lc3b_pipe_pkg::lc3b_wb ex_busy_dest,
	input lc3b_pipe_pkg::lc3b_wb mem_busy_dest,
	input lc3b_pipe_pkg::lc3b_wb wb,
	output logic stall,
	output lc3b_types::lc3b_nzp cc,
	output lc3b_pipe_pkg::lc3b_de_ex de_ex
);
	import lc3b_types::*;
	import lc3b_pipe_pkg::*;

	logic de_valid;
	lc3b_instr de_ir;
	lc3b_word de_pc2;
	lc3b_ctrl ctrl;
	logic use1, use2, hazard;
	lc3b_reg src1_idx, src2_idx;
	lc3b_word regs [8];

	function automatic logic writes(lc3b_wb w, lc3b_reg idx);
		return w.reg_write && (w.dest == idx);
	endfunction

	//////////////////////////////////////////////////
	// decode register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			de_valid <= 1'b0;
		else if (flush)
			de_valid <= 1'b0;
		else if (!stall)
			de_valid <= instr_valid;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			de_ir <= instr;
			de_pc2 <= instr_pc2;
		end
	end

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		use1 = 1'b0;
		use2 = 1'b0;
		case (de_ir.op.opcode)
			op_add, op_and: begin
				ctrl.aluop = (de_ir.op.opcode == op_and) ? alu_and : alu_add;
				ctrl.use_imm = de_ir.op.imm;
				ctrl.reg_write = 1'b1;
				ctrl.load_cc = 1'b1;
				use1 = 1'b1;
				use2 = ~de_ir.op.imm;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.reg_write = 1'b1;
				ctrl.load_cc = 1'b1;
				use1 = 1'b1;
			end
			// LEA leaves the condition code alone on LC-3b
			op_lea: begin
				ctrl.lea = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_ldr, op_ldb: begin
				ctrl.load = 1'b1;
				ctrl.byte_op = (de_ir.op.opcode == op_ldb);
				ctrl.reg_write = 1'b1;
				ctrl.load_cc = 1'b1;
				use1 = 1'b1;
			end
			op_str, op_stb: begin
				ctrl.store = 1'b1;
				ctrl.byte_op = (de_ir.op.opcode == op_stb);
				use1 = 1'b1;
				use2 = 1'b1;
			end
			op_br: ctrl.branch = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// stores read their data register through the second port
	assign src1_idx = de_ir.op.src1;
	assign src2_idx = ctrl.store ? de_ir.mem.dr : de_ir.op.operand.sr.src2;

	// interlock against writers still in execute or memory
	assign hazard = (use1 & (writes(ex_busy_dest, src1_idx) | writes(mem_busy_dest, src1_idx)))
		| (use2 & (writes(ex_busy_dest, src2_idx) | writes(mem_busy_dest, src2_idx)))
		| (ctrl.branch & (ex_busy_dest.load_cc | mem_busy_dest.load_cc));
	assign stall = de_valid & (hazard | hold);

	//////////////////////////////////////////////////
	// register file and condition code
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb.reg_write)
			regs[wb.dest] <= wb.value;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cc <= `LC3B_RESET_CC;
		else if (wb.load_cc)
			cc <= {wb.value[15], wb.value == 16'h0000, ~wb.value[15] & (wb.value != 16'h0000)};
	end

	always_comb begin
		de_ex.valid = de_valid & ~hazard & ~flush;
		de_ex.pc2 = de_pc2;
		de_ex.instr = de_ir;
		de_ex.ctrl = ctrl;
		de_ex.src1 = regs[src1_idx];
		de_ex.src2 = regs[src2_idx];
		de_ex.dest = de_ir.op.dest;
	end

endmodule : decode_stage

/* execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
	input logic clk,
	input logic rst_n,
	input lc3b_pipe_pkg::lc3b_de_ex de_ex,
	input logic hold,
	input lc3b_types::lc3b_nzp cc,
	output lc3b_pipe_pkg::lc3b_ex_mem ex_mem,
	output logic redirect,
	output lc3b_types::lc3b_word redirect_pc,
	output lc3b_pipe_pkg::lc3b_wb busy_dest
);
	import lc3b_types::*;
	import lc3b_pipe_pkg::*;

	logic ex_valid, taken;
	lc3b_de_ex ex_q;
	lc3b_instr ir;
	lc3b_word sext5, sext6, sext9, opnd2, alu_out, addr, target, result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else if (!hold)
			ex_valid <= de_ex.valid;
	end

	always_ff @(posedge clk) begin
		if (!hold)
			ex_q <= de_ex;
	end

	assign ir = ex_q.instr;
	assign sext5 = {{11{ir.op.operand.imm5[4]}}, ir.op.operand.imm5};
	assign sext6 = {{10{ir.mem.offset6[5]}}, ir.mem.offset6};
	assign sext9 = {{7{ir.br.offset9[8]}}, ir.br.offset9};

	//////////////////////////////////////////////////
	// ALU and address generation
	//////////////////////////////////////////////////

	assign opnd2 = ex_q.ctrl.use_imm ? sext5 : ex_q.src2;

	always_comb begin
		case (ex_q.ctrl.aluop)
			alu_and: alu_out = ex_q.src1 & opnd2;
			alu_not: alu_out = ~ex_q.src1;
			default: alu_out = ex_q.src1 + opnd2;
		endcase
	end

	// byte accesses use the offset unscaled
	assign addr = ex_q.src1 + (ex_q.ctrl.byte_op ? sext6 : {sext6[14:0], 1'b0});
	// BR target and LEA value
	assign target = ex_q.pc2 + {sext9[14:0], 1'b0};

	always_comb begin
		if (ex_q.ctrl.lea)
			result = target;
		else if (ex_q.ctrl.load || ex_q.ctrl.store)
			result = addr;
		else
			result = alu_out;
	end

	// redirect only in the cycle the branch leaves execute
	assign taken = ex_valid & ex_q.ctrl.branch & (|(ir.br.nzp & cc));
	assign redirect = taken & ~hold;
	assign redirect_pc = target;

	always_comb begin
		ex_mem.valid = ex_valid;
		ex_mem.ctrl = ex_q.ctrl;
		ex_mem.result = result;
		ex_mem.store_data = ex_q.src2;
		ex_mem.dest = ex_q.dest;
		busy_dest.reg_write = ex_valid & ex_q.ctrl.reg_write;
		busy_dest.dest = ex_q.dest;
		busy_dest.value = result;
		busy_dest.load_cc = ex_valid & ex_q.ctrl.load_cc;
	end

endmodule : execute_stage

/* mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage (
	input logic clk,
	input logic rst_n,
	input lc3b_pipe_pkg::lc3b_ex_mem ex_mem,
	input logic mem_resp_b,
	input lc3b_types::lc3b_word mem_rdata_b,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output lc3b_types::lc3b_word mem_address_b,
	output lc3b_types::lc3b_word mem_wdata_b,
	output logic busy,
	output lc3b_pipe_pkg::lc3b_wb wb,
	output lc3b_pipe_pkg::lc3b_wb busy_dest
);
	import lc3b_types::*;
	import lc3b_pipe_pkg::*;

	logic mem_valid, done;
	lc3b_ex_mem mem_q;
	logic [7:0] load_byte;
	lc3b_word load_val, wb_value;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else if (!busy)
			mem_valid <= ex_mem.valid;
	end

	always_ff @(posedge clk) begin
		if (!busy)
			mem_q <= ex_mem;
	end

	//////////////////////////////////////////////////
	// data port
	//////////////////////////////////////////////////

	// request held from entry until the response cycle
	assign mem_read_b = mem_valid & mem_q.ctrl.load;
	assign mem_write_b = mem_valid & mem_q.ctrl.store;
	assign busy = (mem_read_b | mem_write_b) & ~mem_resp_b;

	// word accesses are aligned, bytes keep bit 0 as lane select
	assign mem_address_b = mem_q.ctrl.byte_op ? mem_q.result : {mem_q.result[15:1], 1'b0};
	assign mem_wdata_b = mem_q.ctrl.byte_op ? {2{mem_q.store_data[7:0]}} : mem_q.store_data;
	assign mem_wmask_b = mem_q.ctrl.byte_op ? {mem_q.result[0], ~mem_q.result[0]} : 2'b11;

	//////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////

	assign load_byte = mem_q.result[0] ? mem_rdata_b[15:8] : mem_rdata_b[7:0];
	assign load_val = mem_q.ctrl.byte_op ? {{8{load_byte[7]}}, load_byte} : mem_rdata_b;
	assign wb_value = mem_q.ctrl.load ? load_val : mem_q.result;
	// loads write only in their response cycle
	assign done = mem_valid & (~mem_q.ctrl.load | mem_resp_b);

	always_comb begin
		wb.reg_write = done & mem_q.ctrl.reg_write;
		wb.dest = mem_q.dest;
		wb.value = wb_value;
		wb.load_cc = done & mem_q.ctrl.load_cc;
		busy_dest.reg_write = mem_valid & mem_q.ctrl.reg_write;
		busy_dest.dest = mem_q.dest;
		busy_dest.value = wb_value;
		busy_dest.load_cc = mem_valid & mem_q.ctrl.load_cc;
	end

endmodule : mem_wb_stage

/* datapath.sv */
`timescale 1ns/1ns

module datapath (
	input logic clk,
	input logic rst_n,
	// instruction port
	input logic mem_resp_a,
	input lc3b_types::lc3b_word mem_rdata_a,
	output logic mem_read_a,
	output lc3b_types::lc3b_word mem_address_a,
	// data port
	input logic mem_resp_b,
	input lc3b_types::lc3b_word mem_rdata_b,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output lc3b_types::lc3b_word mem_address_b,
	output lc3b_types::lc3b_word mem_wdata_b
);
	import lc3b_types::*;
	import lc3b_pipe_pkg::*;

	lc3b_word instr, instr_pc2, redirect_pc;
	logic instr_valid, stall, redirect, busy;
	lc3b_nzp cc;
	lc3b_de_ex de_ex;
	lc3b_ex_mem ex_mem;
	lc3b_wb wb, ex_busy_dest, mem_busy_dest;

	fetch_stage fetch (
		.clk, .rst_n, .mem_resp_a, .mem_rdata_a, .stall, .redirect, .redirect_pc,
		.mem_read_a, .mem_address_a, .instr, .instr_pc2, .instr_valid
	);

	// branch redirect flushes decode, data port back-pressure holds it
	decode_stage decode (
		.clk, .rst_n, .instr, .instr_pc2, .instr_valid,
		.flush(redirect), .hold(busy), .ex_busy_dest, .mem_busy_dest, .wb,
		.stall, .cc, .de_ex
	);

	execute_stage execute (
		.clk, .rst_n, .de_ex, .hold(busy), .cc,
		.ex_mem, .redirect, .redirect_pc, .busy_dest(ex_busy_dest)
	);

	mem_wb_stage mem_wb (
		.clk, .rst_n, .ex_mem, .mem_resp_b, .mem_rdata_b,
		.mem_read_b, .mem_write_b, .mem_wmask_b, .mem_address_b, .mem_wdata_b,
		.busy, .wb, .busy_dest(mem_busy_dest)
	);

endmodule : datapath

/* datapath_asserts.sv */
`timescale 1ns/1ns

module datapath_asserts (
	input logic clk,
	input logic rst_n,
	input logic mem_read_a,
	input logic mem_resp_a,
	input lc3b_types::lc3b_word mem_address_a,
	input logic mem_read_b,
	input logic mem_write_b,
	input logic mem_resp_b,
	input logic [1:0] mem_wmask_b,
	input lc3b_types::lc3b_word mem_address_b,
	input lc3b_types::lc3b_word mem_wdata_b
);
	int fail_count = 0;

	assert property (@(posedge clk) disable iff (!rst_n) !(mem_read_b && mem_write_b))
	else begin
		$error("read and write high together on the data port");
		fail_count++;
	end

	//////////////////////////////////////////////////
	// held requests keep their address and data
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_read_a && !mem_resp_a |=> $stable(mem_address_a))
	else begin
		$error("instruction address changed while the read was pending");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read_b || mem_write_b) && !mem_resp_b |=> $stable(mem_address_b))
	else begin
		$error("data address changed while the request was pending");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_write_b && !mem_resp_b |=> $stable(mem_wdata_b) && $stable(mem_wmask_b))
	else begin
		$error("write data or mask changed while the write was pending");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) mem_write_b |-> mem_wmask_b != 2'b00)
	else begin
		$error("write with an empty byte mask");
		fail_count++;
	end

endmodule : datapath_asserts

/* datapath_tb.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module datapath_tb;
	import lc3b_types::*;

	// one expected access on the data port
	typedef struct packed {
		logic write;
		lc3b_word addr;
		lc3b_word data;
		logic [1:0] mask;
	} data_access;

	logic clk = 1'b0;
	logic rst_n;
	logic mem_read_a, mem_resp_a;
	lc3b_word mem_address_a, mem_rdata_a;
	logic mem_read_b, mem_write_b, mem_resp_b;
	logic [1:0] mem_wmask_b;
	lc3b_word mem_address_b, mem_wdata_b, mem_rdata_b;

	lc3b_word imem [256];
	lc3b_word dmem [32768];
	lc3b_word model_mem [32768];
	data_access exp_q [$];
	lc3b_word lfsr, halt_pc, wait_a, wait_b;
	int errors, checks, cycles;

	datapath uut (
		.clk, .rst_n,
		.mem_resp_a, .mem_rdata_a, .mem_read_a, .mem_address_a,
		.mem_resp_b, .mem_rdata_b, .mem_read_b, .mem_write_b,
		.mem_wmask_b, .mem_address_b, .mem_wdata_b
	);

	bind datapath datapath_asserts protocol_checks (
		.clk, .rst_n, .mem_read_a, .mem_resp_a, .mem_address_a,
		.mem_read_b, .mem_write_b, .mem_resp_b, .mem_wmask_b, .mem_address_b, .mem_wdata_b
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic lc3b_word rand_bits(input int n);
		lc3b_word r;
		logic fb;
		r = 16'h0000;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic lc3b_word fill_word(input logic [14:0] idx);
		return ({1'b0, idx} * 16'h9e37) ^ {idx[7:0], idx[14:7]};
	endfunction

	function automatic lc3b_nzp nzp_of(input lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		else
			return 3'b001;
	endfunction

	task automatic report_mismatch(input string name, input lc3b_word got, input lc3b_word exp);
		errors++;
		$display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, exp);
	endtask

	task automatic expect_access(input logic write, input lc3b_word addr, input lc3b_word data,
		input logic [1:0] mask);
		data_access acc;
		acc.write = write;
		acc.addr = addr;
		acc.data = data;
		acc.mask = mask;
		exp_q.push_back(acc);
	endtask

	//////////////////////////////////////////////////
	// random program
	//////////////////////////////////////////////////

	task automatic generate_program();
		lc3b_word kind, dr, sr, low, pick;
		logic [5:0] opnd;
		int n;
		imem = '{default: 16'h0000};
		n = 0;
		// AND Ri, Ri, #0 for every register
		for (int i = 0; i < 8; i++) begin
			imem[n[7:0]] = {4'b0101, i[2:0], i[2:0], 6'b100000};
			n++;
		end
		for (int i = 0; i < 56; i++) begin
			kind = rand_bits(3);
			dr = rand_bits(3);
			sr = rand_bits(3);
			low = rand_bits(6);
			pick = rand_bits(1);
			opnd = low[5] ? low[5:0] : {3'b000, low[2:0]};
			case (kind[2:0])
				3'd0: imem[n[7:0]] = {4'b0001, dr[2:0], sr[2:0], opnd};
				3'd1: imem[n[7:0]] = {4'b0101, dr[2:0], sr[2:0], opnd};
				3'd2: imem[n[7:0]] = {4'b1001, dr[2:0], sr[2:0], 6'b111111};
				3'd3: imem[n[7:0]] = {4'b1110, dr[2:0], sr[2:0], low[5:0]};
				3'd4: imem[n[7:0]] = {4'b0110, dr[2:0], sr[2:0], low[5:0]};
				3'd5: imem[n[7:0]] = {4'b0010, dr[2:0], sr[2:0], low[5:0]};
				3'd6: imem[n[7:0]] = {pick[0] ? 4'b0011 : 4'b0111, dr[2:0], sr[2:0], low[5:0]};
				// forward by 0 to 3 words so the worst case lands inside the dump
				3'd7: imem[n[7:0]] = {4'b0000, dr[2:0], 7'b0000000, low[1:0]};
			endcase
			n++;
		end
		// STR Ri, R0, #i
		for (int i = 0; i < 8; i++) begin
			imem[n[7:0]] = {4'b0111, i[2:0], 3'b000, 3'b000, i[2:0]};
			n++;
		end
		halt_pc = {n[14:0], 1'b0};
		imem[n[7:0]] = {4'b0000, 3'b111, 9'h1ff};
	endtask

	//////////////////////////////////////////////////
	// ISA reference model
	//////////////////////////////////////////////////

	task automatic run_reference_model();
		lc3b_word r [8];
		lc3b_nzp cc;
		lc3b_word pc, ir, a, v, w, d, off6, off9;
		int steps;
		r = '{default: 16'h0000};
		cc = `LC3B_RESET_CC;
		pc = `LC3B_RESET_PC;
		steps = 0;
		while (pc != halt_pc && steps < 1000) begin
			ir = imem[pc[8:1]];
			pc = pc + 16'd2;
			off6 = {{10{ir[5]}}, ir[5:0]};
			off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
			d = r[ir[11:9]];
			case (ir[15:12])
				4'b0001, 4'b0101: begin
					a = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
					v = ir[14] ? (r[ir[8:6]] & a) : (r[ir[8:6]] + a);
					r[ir[11:9]] = v;
					cc = nzp_of(v);
				end
				4'b1001: begin
					v = ~r[ir[8:6]];
					r[ir[11:9]] = v;
					cc = nzp_of(v);
				end
				4'b1110: r[ir[11:9]] = pc + off9;
				4'b0110, 4'b0010: begin
					if (ir[14]) begin
						a = r[ir[8:6]] + {off6[14:0], 1'b0};
						a[0] = 1'b0;
						v = model_mem[a[15:1]];
					end else begin
						a = r[ir[8:6]] + off6;
						w = model_mem[a[15:1]];
						v = a[0] ? {{8{w[15]}}, w[15:8]} : {{8{w[7]}}, w[7:0]};
					end
					expect_access(1'b0, a, 16'h0000, 2'b00);
					r[ir[11:9]] = v;
					cc = nzp_of(v);
				end
				4'b0111: begin
					a = r[ir[8:6]] + {off6[14:0], 1'b0};
					a[0] = 1'b0;
					model_mem[a[15:1]] = d;
					expect_access(1'b1, a, d, 2'b11);
				end
				4'b0011: begin
					a = r[ir[8:6]] + off6;
					w = model_mem[a[15:1]];
					if (a[0])
						w[15:8] = d[7:0];
					else
						w[7:0] = d[7:0];
					model_mem[a[15:1]] = w;
					expect_access(1'b1, a, {d[7:0], d[7:0]}, a[0] ? 2'b10 : 2'b01);
				end
				4'b0000: begin
					if ((ir[11:9] & cc) != 3'b000)
						pc = pc + off9;
				end
				default: ;
			endcase
			steps++;
		end
	endtask

	//////////////////////////////////////////////////
	// memory models
	//////////////////////////////////////////////////

	task automatic serve_data_port();
		data_access acc;
		lc3b_word w;
		checks++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("%0t ns: data port access at %h after the last expected one",
				$time, mem_address_b);
		end else begin
			acc = exp_q.pop_front();
			if (acc.write != mem_write_b)
				report_mismatch("mem_write_b", {15'b0, mem_write_b}, {15'b0, acc.write});
			if (mem_address_b !== acc.addr)
				report_mismatch("mem_address_b", mem_address_b, acc.addr);
			if (mem_write_b && mem_wdata_b !== acc.data)
				report_mismatch("mem_wdata_b", mem_wdata_b, acc.data);
			if (mem_write_b && mem_wmask_b !== acc.mask)
				report_mismatch("mem_wmask_b", {14'b0, mem_wmask_b}, {14'b0, acc.mask});
		end
		w = dmem[mem_address_b[15:1]];
		if (mem_write_b) begin
			if (mem_wmask_b[0])
				w[7:0] = mem_wdata_b[7:0];
			if (mem_wmask_b[1])
				w[15:8] = mem_wdata_b[15:8];
			dmem[mem_address_b[15:1]] = w;
		end else begin
			mem_rdata_b = w;
		end
	endtask

	// both ports answer after 0 to 3 wait cycles with a one-cycle resp
	always @(negedge clk) begin
		if (mem_resp_a) begin
			mem_resp_a = 1'b0;
		end else if (mem_read_a) begin
			if (wait_a == 16'd0) begin
				mem_rdata_a = imem[mem_address_a[8:1]];
				mem_resp_a = 1'b1;
				wait_a = rand_bits(2);
			end else begin
				wait_a = wait_a - 16'd1;
			end
		end
		if (mem_resp_b) begin
			mem_resp_b = 1'b0;
		end else if (mem_read_b || mem_write_b) begin
			if (wait_b == 16'd0) begin
				serve_data_port();
				mem_resp_b = 1'b1;
				wait_b = rand_bits(2);
			end else begin
				wait_b = wait_b - 16'd1;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		mem_resp_a = 1'b0;
		mem_rdata_a = 16'h0000;
		mem_resp_b = 1'b0;
		mem_rdata_b = 16'h0000;
		errors = 0;
		checks = 0;
		lfsr = 16'd40;
		generate_program();
		for (int i = 0; i < 32768; i++)
			dmem[i[14:0]] = fill_word(i[14:0]);
		model_mem = dmem;
		run_reference_model();
		wait_a = rand_bits(2);
		wait_b = rand_bits(2);

		repeat (4) begin
			@(negedge clk);
			if (mem_read_b !== 1'b0)
				report_mismatch("mem_read_b", {15'b0, mem_read_b}, 16'h0000);
			if (mem_write_b !== 1'b0)
				report_mismatch("mem_write_b", {15'b0, mem_write_b}, 16'h0000);
		end
		rst_n = 1'b1;

		// first cycle out of reset
		@(negedge clk);
		if (mem_read_b !== 1'b0)
			report_mismatch("mem_read_b", {15'b0, mem_read_b}, 16'h0000);
		if (mem_write_b !== 1'b0)
			report_mismatch("mem_write_b", {15'b0, mem_write_b}, 16'h0000);
		if (mem_read_a !== 1'b1)
			report_mismatch("mem_read_a", {15'b0, mem_read_a}, 16'h0001);
		if (mem_address_a !== `LC3B_RESET_PC)
			report_mismatch("mem_address_a", mem_address_a, `LC3B_RESET_PC);

		cycles = 0;
		while (exp_q.size() != 0 && cycles < 5000) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout with %0d expected data accesses never seen", exp_q.size());
		end

		// the halt loop must stay quiet on the data port
		repeat (40) @(negedge clk);

		errors = errors + uut.protocol_checks.fail_count;
		$display("data port checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule : datapath_tb

/* datapath.f */
+incdir+.
lc3b_types.sv
lc3b_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
datapath.sv
datapath_asserts.sv
datapath_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the datapath testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module datapath_tb -f datapath.f -o datapath_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/datapath_sim +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
